//--- logic/noc_route_pkg.sv
package noc_route_pkg;

    // 4x3 mesh with one endpoint per router
    localparam int nx = 4;                  // columns
    localparam int ny = 3;                  // rows
    localparam int rxw = 2;                 // column field width
    localparam int ryw = 2;                 // row field width
    localparam int raw = rxw + ryw;         // router / endpoint address width
    localparam int num_ports = 5;           // local + four mesh directions

    // output port encoding, also the bit index in the one-hot destport
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_east  = 3'd1,                  // larger column
        port_north = 3'd2,                  // smaller row
        port_west  = 3'd3,                  // smaller column
        port_south = 3'd4                   // larger row
    } port_e;

    // column field sits in the low bits
    function automatic logic [rxw-1:0] addr_col(
        input logic [raw-1:0] addr
    );
        return addr[rxw-1:0];
    endfunction

    // row field sits above the column
    function automatic logic [ryw-1:0] addr_row(
        input logic [raw-1:0] addr
    );
        return addr[raw-1:rxw];
    endfunction

    // XY rule, resolve X completely before moving in Y
    function automatic port_e xy_decide(
        input logic [rxw-1:0] cur_x,
        input logic [ryw-1:0] cur_y,
        input logic [rxw-1:0] dst_x,
        input logic [ryw-1:0] dst_y
    );
        port_e port;
        if (dst_x > cur_x) begin
            port = port_east;
        end else if (dst_x < cur_x) begin
            port = port_west;
        end else if (dst_y < cur_y) begin
            port = port_north;              // rows count downward
        end else if (dst_y > cur_y) begin
            port = port_south;
        end else begin
            port = port_local;              // arrived
        end
        return port;
    endfunction

endpackage

//--- logic/xy_port_route.sv
`timescale 1ns/10ps

module xy_port_route
    import noc_route_pkg::*;
(
    input  logic [raw-1:0] current_r_addr,
    input  logic [raw-1:0] dest_e_addr,
    output port_e          conv_port,
    output logic           addr_ok
);

    logic [rxw-1:0] current_rx;
    logic [ryw-1:0] current_ry;
    logic [rxw-1:0] dest_ex;
    logic [ryw-1:0] dest_ey;
    logic           current_ok;
    logic           dest_ok;

    // field split of both addresses
    assign current_rx = addr_col(current_r_addr);
    assign current_ry = addr_row(current_r_addr);
    assign dest_ex    = addr_col(dest_e_addr);
    assign dest_ey    = addr_row(dest_e_addr);

    // column field covers all 4 columns, only the row can overflow
    assign current_ok = (current_ry < ryw'(ny));
    assign dest_ok    = (dest_ey < ryw'(ny));
    assign addr_ok    = current_ok && dest_ok;

    // port taken at this router
    assign conv_port = xy_decide(current_rx, current_ry, dest_ex, dest_ey);

endmodule

//--- logic/lookahead_port_route.sv
`timescale 1ns/10ps

module lookahead_port_route
    import noc_route_pkg::*;
(
    input  logic [raw-1:0] current_r_addr,
    input  logic [raw-1:0] dest_e_addr,
    output port_e          lk_next_port
);

    logic [rxw-1:0] current_rx;
    logic [ryw-1:0] current_ry;
    logic [rxw-1:0] dest_ex;
    logic [ryw-1:0] dest_ey;
    logic [rxw-1:0] next_rx;
    logic [ryw-1:0] next_ry;
    port_e          first_hop;

    assign current_rx = addr_col(current_r_addr);
    assign current_ry = addr_row(current_r_addr);
    assign dest_ex    = addr_col(dest_e_addr);
    assign dest_ey    = addr_row(dest_e_addr);

    // own copy of the first hop so this path runs beside the conventional one
    assign first_hop = xy_decide(current_rx, current_ry, dest_ex, dest_ey);

    // neighbor router reached through first_hop
    always_comb begin
        next_rx = current_rx;
        next_ry = current_ry;
        case (first_hop)
            port_east:  next_rx = current_rx + rxw'(1);
            port_west:  next_rx = current_rx - rxw'(1);
            port_north: next_ry = current_ry - ryw'(1);
            port_south: next_ry = current_ry + ryw'(1);
            default: begin
                next_rx = current_rx;       // local, stays here
                next_ry = current_ry;
            end
        endcase
    end

    // port the neighbor will pick for this header
    always_comb begin
        if (first_hop == port_local) begin
            lk_next_port = port_local;      // no next router
        end else begin
            lk_next_port = xy_decide(next_rx, next_ry, dest_ex, dest_ey);
        end
    end

endmodule

//--- logic/route_merge.sv
`timescale 1ns/10ps

module route_merge
    import noc_route_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hdr_valid,
    input  logic                 lk_port_valid,
    input  port_e                lk_port_in,
    input  port_e                conv_port,
    input  logic                 addr_ok,
    input  port_e                lk_next_port,
    output logic                 route_valid,
    output logic [num_ports-1:0] destport,
    output port_e                lkdestport,
    output logic                 route_err
);

    logic                 lk_mismatch;
    logic                 err_next;
    logic [num_ports-1:0] destport_next;
    port_e                lkdestport_next;

    // upstream look-ahead must agree with what we computed here
    assign lk_mismatch = lk_port_valid && (lk_port_in != conv_port);
    assign err_next    = !addr_ok || lk_mismatch;

    // one-hot port, all zeros drops the header
    always_comb begin
        destport_next = '0;
        if (!err_next) begin
            destport_next[conv_port] = 1'b1;
        end
    end

    assign lkdestport_next = err_next ? port_local : lk_next_port;

    // one result per strobe, one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            route_valid <= 1'b0;
            destport    <= '0;
            lkdestport  <= port_local;
            route_err   <= 1'b0;
        end else begin
            route_valid <= hdr_valid;       // single cycle pulse
            if (hdr_valid) begin
                destport   <= destport_next;
                lkdestport <= lkdestport_next;
                route_err  <= err_next;
            end
        end
    end

endmodule

//--- logic/route_unit_top.sv
`timescale 1ns/10ps

module route_unit_top
    import noc_route_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hdr_valid,
    input  logic [raw-1:0]       current_r_addr,
    input  logic [raw-1:0]       dest_e_addr,
    input  logic                 lk_port_valid,
    input  port_e                lk_port_in,
    output logic                 route_valid,
    output logic [num_ports-1:0] destport,
    output port_e                lkdestport,
    output logic                 route_err
);

    port_e conv_port;
    logic  addr_ok;
    port_e lk_next_port;

    // port at this router plus range check
    xy_port_route xy_port_route_inst (
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .conv_port      (conv_port),
        .addr_ok        (addr_ok)
    );

    // port at the next router, computed in parallel
    lookahead_port_route lookahead_port_route_inst (
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .lk_next_port   (lk_next_port)
    );

    route_merge route_merge_inst (
        .clk           (clk),
        .reset         (reset),
        .hdr_valid     (hdr_valid),
        .lk_port_valid (lk_port_valid),
        .lk_port_in    (lk_port_in),
        .conv_port     (conv_port),
        .addr_ok       (addr_ok),
        .lk_next_port  (lk_next_port),
        .route_valid   (route_valid),
        .destport      (destport),
        .lkdestport    (lkdestport),
        .route_err     (route_err)
    );

endmodule

//--- verif/route_unit_tb.sv
`timescale 1ns/10ps

module route_unit_tb
    import noc_route_pkg::*;
();

    typedef struct packed {
        logic [num_ports-1:0] dest;
        port_e                lk;
        logic                 err;
    } result_t;

    logic                 clk;
    logic                 reset;
    logic                 hdr_valid;
    logic [raw-1:0]       current_r_addr;
    logic [raw-1:0]       dest_e_addr;
    logic                 lk_port_valid;
    port_e                lk_port_in;
    logic                 route_valid;
    logic [num_ports-1:0] destport;
    port_e                lkdestport;
    logic                 route_err;

    result_t expected_q[$];                 // headers in flight
    result_t held;                          // what the outputs must show now
    logic    strobe_seen;                   // strobe taken at the last rising edge
    int      results_checked;
    integer  seed;

    route_unit_top route_unit_top_inst (
        .clk            (clk),
        .reset          (reset),
        .hdr_valid      (hdr_valid),
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .lk_port_valid  (lk_port_valid),
        .lk_port_in     (lk_port_in),
        .route_valid    (route_valid),
        .destport       (destport),
        .lkdestport     (lkdestport),
        .route_err      (route_err)
    );

    always #5 clk = ~clk;                   // 10 ns period

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // one header per trace line, idle gaps after every sixth header
    task automatic play_trace(input int fd, output int hdr_count);
        string      line;
        int         n;
        int         gap;
        logic [7:0] f_cur;
        logic [7:0] f_dst;
        logic [7:0] f_lkv;
        logic [7:0] f_lki;
        logic [7:0] f_dest;
        logic [7:0] f_lk;
        logic [7:0] f_err;
        result_t    exp_res;
        hdr_count = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_cur, f_dst, f_lkv, f_lki, f_dest, f_lk, f_err);
                if (n == 7) begin
                    exp_res.dest = f_dest[num_ports-1:0];
                    exp_res.lk   = port_e'(f_lk[2:0]);
                    exp_res.err  = f_err[0];
                    @(negedge clk);
                    hdr_valid      = 1'b1;
                    current_r_addr = f_cur[raw-1:0];
                    dest_e_addr    = f_dst[raw-1:0];
                    lk_port_valid  = f_lkv[0];
                    lk_port_in     = port_e'(f_lki[2:0]);
                    expected_q.push_back(exp_res);
                    hdr_count++;
                    if (hdr_count % 6 == 0) begin
                        gap = ($random(seed) & 3) + 1;  // 1 to 4 idle cycles
                        @(negedge clk);
                        hdr_valid = 1'b0;
                        repeat (gap - 1) @(negedge clk);
                    end
                end
            end
        end
        @(negedge clk);
        hdr_valid = 1'b0;
    endtask

    // checker, samples mid-cycle where outputs are settled
    initial begin
        held.dest       = '0;               // reset values
        held.lk         = port_local;
        held.err        = 1'b0;
        results_checked = 0;
        forever begin
            @(posedge clk);
            strobe_seen = hdr_valid;
            @(negedge clk);
            if (route_valid === 1'b1 && expected_q.size() == 0) begin
                abort_run("result seen for a header that was never sent");
            end else begin
                if (route_valid === 1'b1) begin
                    held = expected_q.pop_front();
                    results_checked++;
                end
                assert (route_valid === strobe_seen)
                    else report_mismatch("route_valid", 8'(route_valid), 8'(strobe_seen));
                assert (destport === held.dest)
                    else report_mismatch("destport", 8'(destport), 8'(held.dest));
                assert (lkdestport === held.lk)
                    else report_mismatch("lkdestport", 8'(lkdestport), 8'(held.lk));
                assert (route_err === held.err)
                    else report_mismatch("route_err", 8'(route_err), 8'(held.err));
            end
        end
    end

    initial begin
        int fd;
        int hdr_count;
        int drain_wait;
        clk            = 1'b0;
        reset          = 1'b1;
        hdr_valid      = 1'b0;
        current_r_addr = '0;
        dest_e_addr    = '0;
        lk_port_valid  = 1'b0;
        lk_port_in     = port_local;
        seed           = 79638;
        hdr_count      = 0;
        drain_wait     = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);          // outputs must keep reset values
        fd = $fopen("verif/route_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file verif/route_trace.txt");
        end else begin
            play_trace(fd, hdr_count);
            $fclose(fd);
            while (expected_q.size() != 0 && drain_wait < 20) begin
                @(negedge clk);
                drain_wait++;
            end
            repeat (3) @(negedge clk);      // trailing idle cycles
            if (expected_q.size() != 0) begin
                abort_run($sformatf("%0d result(s) never arrived", expected_q.size()));
            end else if (hdr_count == 0 || results_checked != hdr_count) begin
                abort_run($sformatf("sent %0d headers but checked %0d results",
                                    hdr_count, results_checked));
            end else begin
                $display("all tests passed");
                $finish;
            end
        end
    end

endmodule

//--- verif/route_trace.txt
# cur_addr dest_addr lk_valid lk_in | expected destport lkdestport route_err
# all values hex, one header per line
5 7 0 0 02 1 0
5 4 0 0 08 0 0
5 1 0 0 04 0 0
5 9 0 0 10 0 0
0 b 0 4 02 1 0
0 9 0 0 02 4 0
6 6 0 0 01 0 0
b 0 0 0 08 3 0
a 2 0 0 04 2 0
2 b 0 0 02 4 0
5 7 1 1 02 1 0
5 7 1 4 00 0 1
6 6 1 0 01 0 0
0 9 1 2 00 0 1
5 d 0 0 00 0 1
c 0 0 0 00 0 1
3 8 0 0 08 3 0
8 3 0 0 02 1 0
7 b 0 0 10 0 0
9 1 0 0 04 2 0
1 9 0 0 10 4 0
b 0 1 3 08 3 0

//--- sim.f
logic/noc_route_pkg.sv
logic/xy_port_route.sv
logic/lookahead_port_route.sv
logic/route_merge.sv
logic/route_unit_top.sv
verif/route_unit_tb.sv

//--- Makefile
TOP = route_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
